// File: hdl/dcache_defs.svh
// Data cache geometry
// Word, address, line and index sizes shared by the
// package types and the address slicing in the RTL

`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// word and address widths
`define DC_XLEN           32
`define DC_PLEN           32

// line and set organisation
`define DC_BLK_BITS       128
`define DC_WAYS           2
`define DC_IDX_BITS       4

// address fields
`define DC_BLK_OFFS_BITS  4
`define DC_DAT_OFFS_BITS  2
`define DC_TAG_BITS       24

// bus address compare starts above the byte lanes
`define DC_BURST_LSB      2

`endif

// File: hdl/dcache_hit_path.sv
// Data cache hit path
// Qualifies core requests, captures write hits into the
// one-entry write buffer and forms the read word, with
// any pending buffered store merged in

`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_hit_path (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_i,
  input  logic                  wreq_i,
  input  logic                  flush_i,
  input  dcache_pkg::adr_t      adr_i,
  input  dcache_pkg::be_t       be_i,
  input  dcache_pkg::word_t     d_i,
  input  logic                  cache_hit_i,
  input  dcache_pkg::way_t      ways_hit_i,
  input  dcache_pkg::line_t     cache_line_i,
  input  logic                  writebuffer_ack_i,
  output logic                  hit_req_o,
  output logic                  miss_req_o,
  output dcache_pkg::word_t     hit_word_o,
  output logic                  writebuffer_we_o,
  output dcache_pkg::idx_t      writebuffer_idx_o,
  output dcache_pkg::offs_t     writebuffer_offs_o,
  output dcache_pkg::word_t     writebuffer_data_o,
  output dcache_pkg::line_be_t  writebuffer_be_o,
  output dcache_pkg::way_t      writebuffer_ways_hit_o
);

  import dcache_pkg::*;

  logic  valid_req;
  logic  write_hit;
  logic  bypass_we;
  idx_t  idx;
  offs_t dat_offset;
  line_t wb_line;
  line_t merged_line;

  ////////////////////////////////
  // request qualification
  ////////////////////////////////

  assign valid_req  = req_i & ~flush_i;
  assign hit_req_o  = valid_req & cache_hit_i;
  assign miss_req_o = valid_req & ~cache_hit_i;
  assign write_hit  = hit_req_o & wreq_i;

  assign idx        = adr_i[`DC_BLK_OFFS_BITS +: `DC_IDX_BITS];
  assign dat_offset = adr_i[`DC_BLK_OFFS_BITS-1 -: `DC_DAT_OFFS_BITS];

  ////////////////////////////////
  // write buffer
  ////////////////////////////////

  // a new write hit wins over the ack of the old entry
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      writebuffer_we_o <= 1'b0;
    end else if (flush_i) begin
      writebuffer_we_o <= 1'b0;
    end else if (write_hit) begin
      writebuffer_we_o <= 1'b1;
    end else if (writebuffer_ack_i) begin
      writebuffer_we_o <= 1'b0;
    end
  end

  // byte enables move to the word's lanes within the line
  always_ff @(posedge clk_i) begin
    if (write_hit) begin
      writebuffer_idx_o      <= idx;
      writebuffer_offs_o     <= dat_offset;
      writebuffer_data_o     <= d_i;
      writebuffer_be_o       <= line_be_t'(be_i) << (dat_offset * (`DC_XLEN / 8));
      writebuffer_ways_hit_o <= ways_hit_i;
    end
  end

  ////////////////////////////////
  // read word with bypass
  ////////////////////////////////

  assign bypass_we = writebuffer_we_o &
                     (idx == writebuffer_idx_o) &
                     (ways_hit_i == writebuffer_ways_hit_o);

  assign wb_line = {(`DC_BLK_BITS / `DC_XLEN){writebuffer_data_o}};

  always_comb begin
    for (int i = 0; i < `DC_BLK_BITS / 8; i++) begin
      if (bypass_we && writebuffer_be_o[i]) begin
        merged_line[i*8 +: 8] = wb_line[i*8 +: 8];
      end else begin
        merged_line[i*8 +: 8] = cache_line_i[i*8 +: 8];
      end
    end
  end

  assign hit_word_o = merged_line[dat_offset * `DC_XLEN +: `DC_XLEN];

  // payload must be valid whenever the buffer is held
  a_wb_idx_known : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    writebuffer_we_o |-> !$isunknown(writebuffer_idx_o)
  );

endmodule

`default_nettype wire

// File: hdl/dcache_hit_stage.sv
// Data cache hit stage
// Top of the hit stage: request qualification and write
// buffer, miss FSM toward the bus interface, and the
// response toward the core

`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_hit_stage (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // core request
  input  logic                  req_i,
  input  logic                  wreq_i,
  input  dcache_pkg::adr_t      adr_i,
  input  dcache_pkg::be_t       be_i,
  input  dcache_pkg::word_t     d_i,
  input  logic                  flush_i,
  // tag and data memories
  input  logic                  cache_hit_i,
  input  dcache_pkg::way_t      ways_hit_i,
  input  dcache_pkg::line_t     cache_line_i,
  input  logic                  way_dirty_i,
  input  dcache_pkg::way_t      fill_way_i,
  output dcache_pkg::idx_t      idx_o,
  output dcache_pkg::tag_t      core_tag_o,
  output logic                  latchmem_o,
  // bus interface
  output dcache_pkg::biucmd_e   biucmd_o,
  input  logic                  biucmd_ack_i,
  input  logic                  biu_ack_i,
  input  logic                  biu_err_i,
  input  dcache_pkg::word_t     biu_q_i,
  input  dcache_pkg::adr_t      biu_adro_i,
  // write buffer
  output logic                  writebuffer_we_o,
  input  logic                  writebuffer_ack_i,
  output dcache_pkg::idx_t      writebuffer_idx_o,
  output dcache_pkg::offs_t     writebuffer_offs_o,
  output dcache_pkg::word_t     writebuffer_data_o,
  output dcache_pkg::line_be_t  writebuffer_be_o,
  output dcache_pkg::way_t      writebuffer_ways_hit_o,
  // status and response
  output logic                  evict_read_o,
  output logic                  filling_o,
  output dcache_pkg::way_t      fill_way_o,
  output logic                  armed_o,
  output logic                  stall_o,
  output logic                  ack_o,
  output dcache_pkg::word_t     q_o,
  output logic                  err_o
);

  import dcache_pkg::*;

  logic    hit_req;
  logic    miss_req;
  word_t   hit_word;
  memfsm_e memfsm_state;

  // memory index and tag straight from the core address
  assign idx_o      = adr_i[`DC_BLK_OFFS_BITS +: `DC_IDX_BITS];
  assign core_tag_o = adr_i[`DC_PLEN-1 -: `DC_TAG_BITS];

  dcache_hit_path u_hit_path (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .req_i                  (req_i),
    .wreq_i                 (wreq_i),
    .flush_i                (flush_i),
    .adr_i                  (adr_i),
    .be_i                   (be_i),
    .d_i                    (d_i),
    .cache_hit_i            (cache_hit_i),
    .ways_hit_i             (ways_hit_i),
    .cache_line_i           (cache_line_i),
    .writebuffer_ack_i      (writebuffer_ack_i),
    .hit_req_o              (hit_req),
    .miss_req_o             (miss_req),
    .hit_word_o             (hit_word),
    .writebuffer_we_o       (writebuffer_we_o),
    .writebuffer_idx_o      (writebuffer_idx_o),
    .writebuffer_offs_o     (writebuffer_offs_o),
    .writebuffer_data_o     (writebuffer_data_o),
    .writebuffer_be_o       (writebuffer_be_o),
    .writebuffer_ways_hit_o (writebuffer_ways_hit_o)
  );

  dcache_miss_fsm u_miss_fsm (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .flush_i                (flush_i),
    .miss_req_i             (miss_req),
    .way_dirty_i            (way_dirty_i),
    .fill_way_i             (fill_way_i),
    .adr_i                  (adr_i),
    .writebuffer_we_i       (writebuffer_we_o),
    .writebuffer_idx_i      (writebuffer_idx_o),
    .writebuffer_ways_hit_i (writebuffer_ways_hit_o),
    .biucmd_ack_i           (biucmd_ack_i),
    .biu_err_i              (biu_err_i),
    .memfsm_state_o         (memfsm_state),
    .biucmd_o               (biucmd_o),
    .fill_way_o             (fill_way_o),
    .evict_read_o           (evict_read_o),
    .filling_o              (filling_o),
    .armed_o                (armed_o)
  );

  dcache_resp u_resp (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .memfsm_state_i (memfsm_state),
    .hit_req_i      (hit_req),
    .miss_req_i     (miss_req),
    .hit_word_i     (hit_word),
    .adr_i          (adr_i),
    .biu_adro_i     (biu_adro_i),
    .biu_q_i        (biu_q_i),
    .biu_ack_i      (biu_ack_i),
    .biu_err_i      (biu_err_i),
    .stall_o        (stall_o),
    .latchmem_o     (latchmem_o),
    .ack_o          (ack_o),
    .err_o          (err_o),
    .q_o            (q_o)
  );

endmodule

`default_nettype wire

// File: hdl/dcache_miss_fsm.sv
// Data cache memory FSM
// Runs line fills through the bus interface on a miss,
// reads the victim way out first when it is dirty, and
// holds two recovery cycles before rearming

`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_miss_fsm (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  logic                 miss_req_i,
  input  logic                 way_dirty_i,
  input  dcache_pkg::way_t     fill_way_i,
  input  dcache_pkg::adr_t     adr_i,
  input  logic                 writebuffer_we_i,
  input  dcache_pkg::idx_t     writebuffer_idx_i,
  input  dcache_pkg::way_t     writebuffer_ways_hit_i,
  input  logic                 biucmd_ack_i,
  input  logic                 biu_err_i,
  output dcache_pkg::memfsm_e  memfsm_state_o,
  output dcache_pkg::biucmd_e  biucmd_o,
  output dcache_pkg::way_t     fill_way_o,
  output logic                 evict_read_o,
  output logic                 filling_o,
  output logic                 armed_o
);

  import dcache_pkg::*;

  memfsm_e memfsm_state;
  memfsm_e nxt_memfsm_state;
  biucmd_e nxt_biucmd;
  idx_t    idx;
  logic    wb_conflict;
  logic    victim_dirty;
  logic    start_fill;
  logic    evict_read;

  assign idx = adr_i[`DC_BLK_OFFS_BITS +: `DC_IDX_BITS];

  // buffered store to the victim makes it dirty
  // buffer is dropped on a flush
  assign wb_conflict  = writebuffer_we_i & ~flush_i &
                        (idx == writebuffer_idx_i) &
                        (fill_way_i == writebuffer_ways_hit_i);
  assign victim_dirty = way_dirty_i | wb_conflict;

  assign start_fill = (memfsm_state == ARMED) & miss_req_i;

  ////////////////////////////////
  // next state
  ////////////////////////////////

  always_comb begin
    nxt_memfsm_state = memfsm_state;
    nxt_biucmd       = BIUCMD_NOP;
    evict_read       = 1'b0;

    unique case (memfsm_state)
      ARMED: begin
        if (miss_req_i) begin
          // new line is read before the old one leaves
          nxt_biucmd = BIUCMD_READWAY;
          if (victim_dirty) begin
            nxt_memfsm_state = EVICT;
            evict_read       = 1'b1;
          end else begin
            nxt_memfsm_state = READ;
          end
        end
      end

      READ: begin
        if (biucmd_ack_i || biu_err_i) begin
          nxt_memfsm_state = RECOVER0;
        end
      end

      EVICT: begin
        if (biucmd_ack_i || biu_err_i) begin
          nxt_memfsm_state = RECOVER0;
          nxt_biucmd       = BIUCMD_WRITEWAY;
        end
      end

      // index setup, then memory output latch
      RECOVER0: nxt_memfsm_state = RECOVER1;
      RECOVER1: nxt_memfsm_state = ARMED;

      default: nxt_memfsm_state = ARMED;
    endcase
  end

  ////////////////////////////////
  // state and outputs
  ////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      memfsm_state <= ARMED;
      biucmd_o     <= BIUCMD_NOP;
      evict_read_o <= 1'b0;
      filling_o    <= 1'b0;
      armed_o      <= 1'b1;
    end else begin
      memfsm_state <= nxt_memfsm_state;
      biucmd_o     <= nxt_biucmd;
      evict_read_o <= evict_read;
      filling_o    <= (nxt_memfsm_state == READ) | (nxt_memfsm_state == EVICT);
      armed_o      <= (nxt_memfsm_state == ARMED);
    end
  end

  // fill goes to the way that was read
  always_ff @(posedge clk_i) begin
    if (start_fill) begin
      fill_way_o <= fill_way_i;
    end
  end

  assign memfsm_state_o = memfsm_state;

  // writeback only right after leaving EVICT
  a_writeway_after_evict : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (biucmd_o == BIUCMD_WRITEWAY) |->
      ($past(memfsm_state) == EVICT) && (memfsm_state == RECOVER0)
  );

  a_state_legal : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(memfsm_state) &&
      (memfsm_state inside {ARMED, READ, EVICT, RECOVER0, RECOVER1})
  );

endmodule

`default_nettype wire

// File: hdl/dcache_pkg.sv
// Data cache types
// Memory FSM states, BIU commands and the word, line,
// address and way types of the hit stage

`default_nettype none

`include "dcache_defs.svh"

package dcache_pkg;

  // miss handling states
  typedef enum logic [2:0] {
    ARMED,
    READ,
    EVICT,
    RECOVER0,
    RECOVER1
  } memfsm_e;

  // commands toward the bus interface
  typedef enum logic [1:0] {
    BIUCMD_NOP,
    BIUCMD_READWAY,
    BIUCMD_WRITEWAY
  } biucmd_e;

  typedef logic [`DC_XLEN-1:0]         word_t;
  typedef logic [`DC_XLEN/8-1:0]       be_t;
  typedef logic [`DC_BLK_BITS-1:0]     line_t;
  typedef logic [`DC_BLK_BITS/8-1:0]   line_be_t;
  typedef logic [`DC_PLEN-1:0]         adr_t;
  typedef logic [`DC_IDX_BITS-1:0]     idx_t;
  typedef logic [`DC_TAG_BITS-1:0]     tag_t;
  typedef logic [`DC_DAT_OFFS_BITS-1:0] offs_t;
  typedef logic [`DC_WAYS-1:0]         way_t;

endpackage

`default_nettype wire

// File: hdl/dcache_resp.sv
// Data cache response
// Stall and memory latch decode per FSM state, and the
// registered ack, read data and error toward the core

`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_resp (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  dcache_pkg::memfsm_e  memfsm_state_i,
  input  logic                 hit_req_i,
  input  logic                 miss_req_i,
  input  dcache_pkg::word_t    hit_word_i,
  input  dcache_pkg::adr_t     adr_i,
  input  dcache_pkg::adr_t     biu_adro_i,
  input  dcache_pkg::word_t    biu_q_i,
  input  logic                 biu_ack_i,
  input  logic                 biu_err_i,
  output logic                 stall_o,
  output logic                 latchmem_o,
  output logic                 ack_o,
  output logic                 err_o,
  output dcache_pkg::word_t    q_o
);

  import dcache_pkg::*;

  logic biu_match;
  logic biu_req_ack;

  assign biu_match = biu_adro_i[`DC_PLEN-1:`DC_BURST_LSB] == adr_i[`DC_PLEN-1:`DC_BURST_LSB];

  // bus data for the requested word during a fill
  assign biu_req_ack = (hit_req_i | miss_req_i) & biu_ack_i & biu_match;

  ////////////////////////////////
  // stall and latch
  ////////////////////////////////

  always_comb begin
    unique case (memfsm_state_i)
      ARMED: begin
        stall_o    = miss_req_i;
        latchmem_o = ~stall_o;
      end
      // a flushed pipe has nothing left to wait for
      READ, EVICT: begin
        stall_o    = ~flush_i & ~(hit_req_i | biu_req_ack);
        latchmem_o = ~stall_o;
      end
      RECOVER0: begin
        stall_o    = 1'b1;
        latchmem_o = 1'b0;
      end
      default: begin
        stall_o    = 1'b1;
        latchmem_o = 1'b1;
      end
    endcase
  end

  ////////////////////////////////
  // core response
  ////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
    end else begin
      unique case (memfsm_state_i)
        ARMED:       ack_o <= hit_req_i;
        READ, EVICT: ack_o <= hit_req_i | biu_req_ack;
        default:     ack_o <= 1'b0;
      endcase
      err_o <= biu_err_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if ((memfsm_state_i == READ || memfsm_state_i == EVICT) && !hit_req_i) begin
      q_o <= biu_q_i;
    end else begin
      q_o <= hit_word_i;
    end
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+hdl
hdl/dcache_pkg.sv
hdl/dcache_hit_path.sv
hdl/dcache_miss_fsm.sv
hdl/dcache_resp.sv
hdl/dcache_hit_stage.sv
tests/tb_dcache_hit_stage.sv

// File: tests/tb_dcache_hit_stage.sv
// Testbench for the data cache hit stage
// Drives read and write hits, buffered store bypass, clean
// and dirty misses, bus errors and flushes, and checks the
// responses against a reference model of the hit word

`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module tb_dcache_hit_stage;

  import dcache_pkg::*;

  localparam tag_t TAG_A = 24'h5a17c3;
  localparam tag_t TAG_B = 24'h3c1e00;
  localparam int   ARMED_TIMEOUT = 40;

  logic     clk_i;
  logic     rst_ni;
  logic     req_i;
  logic     wreq_i;
  adr_t     adr_i;
  be_t      be_i;
  word_t    d_i;
  logic     flush_i;
  logic     cache_hit_i;
  way_t     ways_hit_i;
  line_t    cache_line_i;
  logic     way_dirty_i;
  way_t     fill_way_i;
  idx_t     idx_o;
  tag_t     core_tag_o;
  logic     latchmem_o;
  biucmd_e  biucmd_o;
  logic     biucmd_ack_i;
  logic     biu_ack_i;
  logic     biu_err_i;
  word_t    biu_q_i;
  adr_t     biu_adro_i;
  logic     writebuffer_we_o;
  logic     writebuffer_ack_i;
  idx_t     writebuffer_idx_o;
  offs_t    writebuffer_offs_o;
  word_t    writebuffer_data_o;
  line_be_t writebuffer_be_o;
  way_t     writebuffer_ways_hit_o;
  logic     evict_read_o;
  logic     filling_o;
  way_t     fill_way_o;
  logic     armed_o;
  logic     stall_o;
  logic     ack_o;
  word_t    q_o;
  logic     err_o;

  // bookkeeping
  word_t    rng_state;
  int       err_count;
  int       check_count;
  int       tests_run;
  int       tests_failed;
  int       test_err_start;
  string    cur_test;
  int       armed_cycles;

  // expected read data, one entry per acked request
  word_t    exp_q[$];
  bit       chk_q[$];
  word_t    exp_word;
  bit       exp_chk;

  // write buffer model
  bit       wb_valid;
  idx_t     wb_idx;
  way_t     wb_way;
  offs_t    wb_offs;
  be_t      wb_be;
  word_t    wb_data;

  dcache_hit_stage u_dcache_hit_stage (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .req_i                  (req_i),
    .wreq_i                 (wreq_i),
    .adr_i                  (adr_i),
    .be_i                   (be_i),
    .d_i                    (d_i),
    .flush_i                (flush_i),
    .cache_hit_i            (cache_hit_i),
    .ways_hit_i             (ways_hit_i),
    .cache_line_i           (cache_line_i),
    .way_dirty_i            (way_dirty_i),
    .fill_way_i             (fill_way_i),
    .idx_o                  (idx_o),
    .core_tag_o             (core_tag_o),
    .latchmem_o             (latchmem_o),
    .biucmd_o               (biucmd_o),
    .biucmd_ack_i           (biucmd_ack_i),
    .biu_ack_i              (biu_ack_i),
    .biu_err_i              (biu_err_i),
    .biu_q_i                (biu_q_i),
    .biu_adro_i             (biu_adro_i),
    .writebuffer_we_o       (writebuffer_we_o),
    .writebuffer_ack_i      (writebuffer_ack_i),
    .writebuffer_idx_o      (writebuffer_idx_o),
    .writebuffer_offs_o     (writebuffer_offs_o),
    .writebuffer_data_o     (writebuffer_data_o),
    .writebuffer_be_o       (writebuffer_be_o),
    .writebuffer_ways_hit_o (writebuffer_ways_hit_o),
    .evict_read_o           (evict_read_o),
    .filling_o              (filling_o),
    .fill_way_o             (fill_way_o),
    .armed_o                (armed_o),
    .stall_o                (stall_o),
    .ack_o                  (ack_o),
    .q_o                    (q_o),
    .err_o                  (err_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////////////////
  // reference model
  ////////////////////////////////

  function automatic word_t next_random();
    word_t x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic adr_t make_adr(tag_t tag, idx_t idx, offs_t offs);
    return {tag, idx, offs, 2'b00};
  endfunction

  // word byte enables placed in the lanes of the addressed word
  function automatic line_be_t expected_line_be(be_t be, offs_t offs);
    line_be_t r;
    r = '0;
    for (int b = 0; b < `DC_XLEN / 8; b++) begin
      r[offs * (`DC_XLEN / 8) + b] = be[b];
    end
    return r;
  endfunction

  // addressed word, with the buffered bytes when set, way and word match
  function automatic word_t ref_hit_word(line_t line, idx_t idx, way_t way, offs_t offs,
                                         bit b_valid, idx_t b_idx, way_t b_way,
                                         offs_t b_offs, be_t b_be, word_t b_data);
    word_t w;
    w = line[offs * `DC_XLEN +: `DC_XLEN];
    if (b_valid && b_idx == idx && b_way == way && b_offs == offs) begin
      for (int b = 0; b < `DC_XLEN / 8; b++) begin
        if (b_be[b]) begin
          w[b*8 +: 8] = b_data[b*8 +: 8];
        end
      end
    end
    return w;
  endfunction

  ////////////////////////////////
  // checks and reporting
  ////////////////////////////////

  task automatic report_error(input string msg);
    err_count++;
    $display("ERROR %s: %s", cur_test, msg);
  endtask

  task automatic check_word(input string what, input word_t exp, input word_t act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("CHECK FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_cmd(input string what, input biucmd_e exp, input biucmd_e act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("CHECK FAILED %s %s: expected %s, actual %s", cur_test, what,
               exp.name(), act.name());
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("CHECK FAILED %s %s: expected %b, actual %b", cur_test, what, exp, act);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test       = name;
    test_err_start = err_count;
  endtask

  // finish on a rising edge so the data checker has seen the last ack
  task automatic end_test();
    int errs;
    @(posedge clk_i);
    errs = err_count - test_err_start;
    tests_run++;
    if (errs != 0) begin
      tests_failed++;
    end
    $display("test %s: %0d errors, %s", cur_test, errs, (errs == 0) ? "ok" : "FAILED");
  endtask

  // compares read data whenever the DUT acks
  always @(negedge clk_i) begin
    if (rst_ni === 1'b1 && ack_o === 1'b1) begin
      if (exp_q.size() == 0) begin
        report_error("ack_o went high with no request outstanding");
      end else begin
        exp_word = exp_q.pop_front();
        exp_chk  = chk_q.pop_front();
        if (exp_chk) begin
          check_word("q_o", exp_word, q_o);
        end
      end
    end
  end

  ////////////////////////////////
  // stimulus tasks
  ////////////////////////////////

  task automatic idle_inputs();
    req_i             = 1'b0;
    wreq_i            = 1'b0;
    flush_i           = 1'b0;
    cache_hit_i       = 1'b0;
    be_i              = '0;
    d_i               = '0;
    way_dirty_i       = 1'b0;
    biucmd_ack_i      = 1'b0;
    biu_ack_i         = 1'b0;
    biu_err_i         = 1'b0;
    writebuffer_ack_i = 1'b0;
  endtask

  task automatic random_line();
    cache_line_i = {next_random(), next_random(), next_random(), next_random()};
  endtask

  task automatic read_hit(input idx_t idx, input offs_t offs, input way_t way);
    @(negedge clk_i);
    random_line();
    req_i       = 1'b1;
    wreq_i      = 1'b0;
    cache_hit_i = 1'b1;
    ways_hit_i  = way;
    adr_i       = make_adr(TAG_A, idx, offs);
    exp_q.push_back(ref_hit_word(cache_line_i, idx, way, offs,
                                 wb_valid, wb_idx, wb_way, wb_offs, wb_be, wb_data));
    chk_q.push_back(1'b1);
    @(negedge clk_i);
    check_bit("ack_o", 1'b1, ack_o);
    check_bit("stall_o", 1'b0, stall_o);
    check_bit("latchmem_o", 1'b1, latchmem_o);
    check_word("idx_o", word_t'(idx), word_t'(idx_o));
    check_word("core_tag_o", word_t'(TAG_A), word_t'(core_tag_o));
    req_i       = 1'b0;
    cache_hit_i = 1'b0;
  endtask

  task automatic write_hit(input idx_t idx, input offs_t offs, input way_t way,
                           input be_t be, input word_t data);
    @(negedge clk_i);
    req_i       = 1'b1;
    wreq_i      = 1'b1;
    cache_hit_i = 1'b1;
    ways_hit_i  = way;
    adr_i       = make_adr(TAG_A, idx, offs);
    be_i        = be;
    d_i         = data;
    // a write hit is acked too, its data is not checked
    exp_q.push_back('0);
    chk_q.push_back(1'b0);
    @(negedge clk_i);
    wb_valid = 1'b1;
    wb_idx   = idx;
    wb_way   = way;
    wb_offs  = offs;
    wb_be    = be;
    wb_data  = data;
    check_bit("writebuffer_we_o", 1'b1, writebuffer_we_o);
    check_word("writebuffer_idx_o", word_t'(idx), word_t'(writebuffer_idx_o));
    check_word("writebuffer_offs_o", word_t'(offs), word_t'(writebuffer_offs_o));
    check_word("writebuffer_data_o", data, writebuffer_data_o);
    check_word("writebuffer_be_o", word_t'(expected_line_be(be, offs)),
               word_t'(writebuffer_be_o));
    check_word("writebuffer_ways_hit_o", word_t'(way), word_t'(writebuffer_ways_hit_o));
    req_i       = 1'b0;
    wreq_i      = 1'b0;
    cache_hit_i = 1'b0;
  endtask

  task automatic release_buffer();
    @(negedge clk_i);
    check_bit("writebuffer_we_o held", 1'b1, writebuffer_we_o);
    writebuffer_ack_i = 1'b1;
    @(negedge clk_i);
    check_bit("writebuffer_we_o after ack", 1'b0, writebuffer_we_o);
    writebuffer_ack_i = 1'b0;
    wb_valid          = 1'b0;
  endtask

  // counts cycles until armed_o, bus strobes last one cycle
  task automatic wait_armed(output int cycles);
    bit done;
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < ARMED_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
      biucmd_ack_i = 1'b0;
      biu_ack_i    = 1'b0;
      if (armed_o === 1'b1) begin
        done = 1'b1;
      end
    end
    if (!done) begin
      report_error("armed_o did not return within the timeout");
    end
  endtask

  ////////////////////////////////
  // test sequence
  ////////////////////////////////

  initial begin
    rng_state    = 32'h2bd598dc;
    err_count    = 0;
    check_count  = 0;
    tests_run    = 0;
    tests_failed = 0;
    wb_valid     = 1'b0;
    rst_ni       = 1'b0;
    idle_inputs();
    adr_i        = '0;
    ways_hit_i   = '0;
    cache_line_i = '0;
    fill_way_i   = '0;
    biu_q_i      = '0;
    biu_adro_i   = '0;

    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;

    begin_test("reset");
    check_bit("armed_o", 1'b1, armed_o);
    check_bit("ack_o", 1'b0, ack_o);
    check_bit("err_o", 1'b0, err_o);
    check_bit("writebuffer_we_o", 1'b0, writebuffer_we_o);
    check_bit("evict_read_o", 1'b0, evict_read_o);
    check_bit("filling_o", 1'b0, filling_o);
    check_cmd("biucmd_o", BIUCMD_NOP, biucmd_o);
    end_test();

    // error strobe comes back one cycle later
    begin_test("bus_error");
    @(negedge clk_i);
    biu_err_i = 1'b1;
    @(negedge clk_i);
    check_bit("err_o", 1'b1, err_o);
    biu_err_i = 1'b0;
    @(negedge clk_i);
    check_bit("err_o", 1'b0, err_o);
    end_test();

    begin_test("read_hit");
    for (int o = 0; o < 4; o++) begin
      read_hit(4'h3, offs_t'(o), 2'b01);
    end
    end_test();

    begin_test("write_hit");
    write_hit(4'h5, 2'd2, 2'b10, 4'b0110, next_random());
    @(negedge clk_i);
    check_bit("writebuffer_we_o without ack", 1'b1, writebuffer_we_o);
    release_buffer();
    end_test();

    // merge only for the same set, way and word
    begin_test("bypass");
    write_hit(4'h9, 2'd1, 2'b01, 4'b1001, next_random());
    read_hit(4'h9, 2'd1, 2'b01);
    read_hit(4'h9, 2'd0, 2'b01);
    read_hit(4'h9, 2'd1, 2'b10);
    read_hit(4'h8, 2'd1, 2'b01);
    release_buffer();
    read_hit(4'h9, 2'd1, 2'b01);
    end_test();

    begin_test("clean_miss");
    @(negedge clk_i);
    req_i       = 1'b1;
    wreq_i      = 1'b0;
    cache_hit_i = 1'b0;
    way_dirty_i = 1'b0;
    fill_way_i  = 2'b01;
    adr_i       = make_adr(TAG_B, 4'h7, 2'd2);
    @(negedge clk_i);
    check_cmd("biucmd_o", BIUCMD_READWAY, biucmd_o);
    check_bit("filling_o", 1'b1, filling_o);
    check_bit("evict_read_o", 1'b0, evict_read_o);
    check_bit("armed_o", 1'b0, armed_o);
    check_bit("stall_o", 1'b1, stall_o);
    check_bit("latchmem_o", 1'b0, latchmem_o);
    @(negedge clk_i);
    check_cmd("biucmd_o", BIUCMD_NOP, biucmd_o);
    check_bit("filling_o", 1'b1, filling_o);
    // requested word arrives from the bus
    biu_ack_i  = 1'b1;
    biu_adro_i = adr_i;
    biu_q_i    = next_random();
    exp_q.push_back(biu_q_i);
    chk_q.push_back(1'b1);
    @(negedge clk_i);
    check_bit("ack_o", 1'b1, ack_o);
    check_bit("stall_o", 1'b0, stall_o);
    biu_ack_i = 1'b0;
    req_i     = 1'b0;
    @(negedge clk_i);
    check_bit("filling_o", 1'b1, filling_o);
    biucmd_ack_i = 1'b1;
    wait_armed(armed_cycles);
    check_word("armed_o latency", 32'd3, word_t'(armed_cycles));
    check_bit("filling_o", 1'b0, filling_o);
    end_test();

    begin_test("dirty_miss");
    @(negedge clk_i);
    req_i       = 1'b1;
    wreq_i      = 1'b0;
    cache_hit_i = 1'b0;
    way_dirty_i = 1'b1;
    fill_way_i  = 2'b10;
    adr_i       = make_adr(TAG_B, 4'hb, 2'd0);
    @(negedge clk_i);
    check_bit("evict_read_o", 1'b1, evict_read_o);
    check_cmd("biucmd_o", BIUCMD_READWAY, biucmd_o);
    check_bit("filling_o", 1'b1, filling_o);
    check_word("fill_way_o", word_t'(2'b10), word_t'(fill_way_o));
    req_i       = 1'b0;
    way_dirty_i = 1'b0;
    @(negedge clk_i);
    check_bit("evict_read_o", 1'b0, evict_read_o);
    check_cmd("biucmd_o", BIUCMD_NOP, biucmd_o);
    biucmd_ack_i = 1'b1;
    @(negedge clk_i);
    check_cmd("biucmd_o", BIUCMD_WRITEWAY, biucmd_o);
    check_bit("armed_o", 1'b0, armed_o);
    biucmd_ack_i = 1'b0;
    @(negedge clk_i);
    check_cmd("biucmd_o", BIUCMD_NOP, biucmd_o);
    wait_armed(armed_cycles);
    check_word("armed_o latency", 32'd3, word_t'(armed_cycles + 2));
    end_test();

    begin_test("flush");
    @(negedge clk_i);
    req_i       = 1'b1;
    wreq_i      = 1'b1;
    cache_hit_i = 1'b1;
    ways_hit_i  = 2'b01;
    flush_i     = 1'b1;
    adr_i       = make_adr(TAG_A, 4'h2, 2'd3);
    be_i        = 4'hf;
    d_i         = next_random();
    @(negedge clk_i);
    check_bit("ack_o", 1'b0, ack_o);
    check_bit("writebuffer_we_o", 1'b0, writebuffer_we_o);
    wreq_i = 1'b0;
    @(negedge clk_i);
    check_bit("ack_o", 1'b0, ack_o);
    idle_inputs();
    // a flush also drops a pending store
    write_hit(4'h2, 2'd3, 2'b01, 4'hf, next_random());
    @(negedge clk_i);
    check_bit("writebuffer_we_o", 1'b1, writebuffer_we_o);
    flush_i = 1'b1;
    @(negedge clk_i);
    check_bit("writebuffer_we_o after flush", 1'b0, writebuffer_we_o);
    flush_i  = 1'b0;
    wb_valid = 1'b0;
    end_test();

    repeat (2) @(negedge clk_i);
    if (exp_q.size() != 0) begin
      report_error($sformatf("%0d requests were never acked", exp_q.size()));
    end

    $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, err_count);
    if (err_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
